// File: exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define EXEC_WORD_BITS 32  // Datapath word width

`define OPCODE_HI     24   // Data-processing opcode field
`define OPCODE_LO     21
`define SBIT          20   // Set flags
`define IBIT          25   // Immediate second operand
`define UBIT          23   // Load/store offset direction
`define REGSHIFT_BIT  4    // Shift amount held in rs
`define CLASS_HI      27   // Major instruction class
`define CLASS_LO      26

`endif

// File: execTypes_pkg.sv
package execTypes_pkg;

  // How the second operand is formed
  typedef enum logic [1:0] {
    opImm      = 2'b00,  // Rotated 8-bit immediate
    opRegImm   = 2'b01,  // rm shifted by instruction amount
    opRegReg   = 2'b10,  // rm shifted by rs
    opMemShift = 2'b11   // Load/store with shifted rm offset
  } operandClass;

  // Data-processing opcodes, same order as the instruction field
  typedef enum logic [3:0] {
    AND = 4'h0,
    EOR = 4'h1,
    SUB = 4'h2,
    RSB = 4'h3,
    ADD = 4'h4,
    ADC = 4'h5,
    SBC = 4'h6,
    RSC = 4'h7,
    TST = 4'h8,  // Flags only from here to CMN
    TEQ = 4'h9,
    CMP = 4'hA,
    CMN = 4'hB,
    ORR = 4'hC,
    MOV = 4'hD,
    BIC = 4'hE,
    MVN = 4'hF
  } aluOp;

endpackage

// File: instrDecode.sv
`include "exec_settings.svh"

module instrDecode import execTypes_pkg::*; (
  input  logic [`EXEC_WORD_BITS-1:0] instr,
  input  logic [`EXEC_WORD_BITS-1:0] rmVal,
  input  logic [`EXEC_WORD_BITS-1:0] rsVal,
  output operandClass                opClass,
  output aluOp                       op,
  output logic                       setFlags,
  output logic                       isMem,
  output logic                       up,
  output logic [`EXEC_WORD_BITS-1:0] a,
  output logic [`EXEC_WORD_BITS-1:0] b,
  output logic                       isRtype,
  output logic                       isRSRtype,
  output logic                       isMemShift,
  output logic                       ZeroRotate,
  output logic [1:0]                 shiftOpCode_E
);

  logic [3:0]                   rotField;
  logic [7:0]                   imm8;
  logic [2*`EXEC_WORD_BITS-1:0] immWide;
  logic [`EXEC_WORD_BITS-1:0]   rotImm;

  assign rotField = instr[11:8];
  assign imm8     = instr[7:0];

  // Rotate right by twice the field, done on a doubled copy
  assign immWide = {{(`EXEC_WORD_BITS-8){1'b0}}, imm8,
                    {(`EXEC_WORD_BITS-8){1'b0}}, imm8} >> {rotField, 1'b0};
  assign rotImm  = immWide[`EXEC_WORD_BITS-1:0];

  always_comb begin
    if (instr[`CLASS_HI:`CLASS_LO] == 2'b01) begin
      opClass = opMemShift;  // Single data transfer
    end else if (instr[`IBIT]) begin
      opClass = opImm;
    end else if (instr[`REGSHIFT_BIT]) begin
      opClass = opRegReg;
    end else begin
      opClass = opRegImm;
    end
  end

  assign isMem    = (opClass == opMemShift);
  assign up       = instr[`UBIT];
  assign setFlags = instr[`SBIT];

  // Address arithmetic picks its direction from U
  always_comb begin
    if (isMem) begin
      op = up ? ADD : SUB;
    end else begin
      op = aluOp'(instr[`OPCODE_HI:`OPCODE_LO]);
    end
  end

  assign isRtype       = (opClass == opRegImm);
  assign isRSRtype     = (opClass == opRegReg);
  assign isMemShift    = isMem;
  assign ZeroRotate    = (rotField == 4'd0);
  assign shiftOpCode_E = instr[6:5];

  // Shifter sees the instruction word unless the amount lives in rs
  assign a = isRSRtype ? rsVal : instr;
  assign b = (opClass == opImm) ? rotImm : rmVal;

endmodule

// File: shifter.sv
`include "exec_settings.svh"

module shifter (
  input  logic [`EXEC_WORD_BITS-1:0] a,
  input  logic [`EXEC_WORD_BITS-1:0] b,
  input  logic                       isRtype,
  input  logic                       isRSRtype,
  input  logic                       isMemShift,
  input  logic                       ZeroRotate,
  input  logic                       prevCarry,
  input  logic [1:0]                 shiftOpCode_E,
  output logic [`EXEC_WORD_BITS-1:0] shiftBE,
  output logic                       shifterCarryOutE
);

  logic                         immForm;  // Amount and type from the instruction
  logic [1:0]                   shType;
  logic [4:0]                   immAmt;
  logic [7:0]                   shAmt;
  logic [`EXEC_WORD_BITS:0]     lslWide;
  logic [`EXEC_WORD_BITS:0]     lsrWide;
  logic [`EXEC_WORD_BITS:0]     asrWide;
  logic [2*`EXEC_WORD_BITS-1:0] rorWide;
  logic [`EXEC_WORD_BITS-1:0]   coreVal;
  logic                         coreCarry;

  assign immForm = isRtype | isMemShift;
  assign immAmt  = a[11:7];
  assign shType  = immForm ? a[6:5] : shiftOpCode_E;

  // Immediate LSR #0 and ASR #0 stand for a shift by 32
  always_comb begin
    if (!immForm) begin
      shAmt = a[7:0];  // Bottom byte of rs
    end else if (immAmt == 5'd0 && (shType == 2'b01 || shType == 2'b10)) begin
      shAmt = 8'd32;
    end else begin
      shAmt = {3'b000, immAmt};
    end
  end

  // The spare bit on each wide value holds the last bit shifted out.
  // Amounts of 32 and above then fall out of the plain shift operators.
  assign lslWide = {1'b0, b} << shAmt;
  assign lsrWide = {b, 1'b0} >> shAmt;
  assign asrWide = $signed({b, 1'b0}) >>> shAmt;
  assign rorWide = {b, b} >> shAmt[4:0];

  always_comb begin
    coreVal   = b;          // Amount zero keeps rm
    coreCarry = prevCarry;  // and the old carry
    case (shType)
      2'b00: begin  // LSL
        if (shAmt != 8'd0) begin
          coreVal   = lslWide[`EXEC_WORD_BITS-1:0];
          coreCarry = lslWide[`EXEC_WORD_BITS];
        end
      end
      2'b01: begin  // LSR
        if (shAmt != 8'd0) begin
          coreVal   = lsrWide[`EXEC_WORD_BITS:1];
          coreCarry = lsrWide[0];
        end
      end
      2'b10: begin  // ASR, saturates to the sign
        if (shAmt != 8'd0) begin
          coreVal   = asrWide[`EXEC_WORD_BITS:1];
          coreCarry = asrWide[0];
        end
      end
      default: begin
        if (immForm && shAmt == 8'd0) begin  // RRX through the carry
          coreVal   = {prevCarry, b[`EXEC_WORD_BITS-1:1]};
          coreCarry = b[0];
        end else if (shAmt != 8'd0) begin
          // Multiples of 32 leave rm unrotated, carry from bit 31
          coreVal   = rorWide[`EXEC_WORD_BITS-1:0];
          coreCarry = rorWide[`EXEC_WORD_BITS-1];
        end
      end
    endcase
  end

  always_comb begin
    if (isMemShift) begin
      shiftBE          = coreVal;
      shifterCarryOutE = 1'b0;  // Address offset, carry unused
    end else if (isRtype | isRSRtype) begin
      shiftBE          = coreVal;
      shifterCarryOutE = coreCarry;
    end else begin
      // Rotated immediate arrives already formed
      shiftBE          = b;
      shifterCarryOutE = ZeroRotate ? prevCarry : b[`EXEC_WORD_BITS-1];
    end
  end

endmodule

// File: alu.sv
`include "exec_settings.svh"

module alu import execTypes_pkg::*; (
  input  logic [`EXEC_WORD_BITS-1:0] rn,
  input  logic [`EXEC_WORD_BITS-1:0] operand,
  input  logic                       shiftCarry,
  input  logic                       carryIn,
  input  logic                       overflowIn,
  input  aluOp                       op,
  input  logic                       isMem,
  output logic [`EXEC_WORD_BITS-1:0] aluResult,
  output logic [3:0]                 nzcvNext,
  output logic                       writesReg
);

  logic [`EXEC_WORD_BITS-1:0] addA;
  logic [`EXEC_WORD_BITS-1:0] addB;
  logic                       addCin;
  logic [`EXEC_WORD_BITS:0]   sum;
  logic                       sumOverflow;
  logic                       isArith;
  logic                       isCompare;

  // Operand order, inversion and carry for the single adder
  always_comb begin
    addA   = rn;
    addB   = operand;
    addCin = 1'b0;
    case (op)
      SUB, CMP: begin
        addB   = ~operand;
        addCin = 1'b1;
      end
      RSB: begin
        addA   = operand;
        addB   = ~rn;
        addCin = 1'b1;
      end
      ADC:     addCin = carryIn;
      SBC: begin
        addB   = ~operand;
        addCin = carryIn;
      end
      RSC: begin
        addA   = operand;
        addB   = ~rn;
        addCin = carryIn;
      end
      default: addCin = 1'b0;  // ADD, CMN and the logical ops
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {{`EXEC_WORD_BITS{1'b0}}, addCin};
  // Like-signed inputs with an unlike-signed sum
  assign sumOverflow = (addA[`EXEC_WORD_BITS-1] == addB[`EXEC_WORD_BITS-1]) &&
                       (sum[`EXEC_WORD_BITS-1] != addA[`EXEC_WORD_BITS-1]);

  assign isArith   = (op inside {SUB, RSB, ADD, ADC, SBC, RSC, CMP, CMN});
  assign isCompare = (op inside {TST, TEQ, CMP, CMN});

  always_comb begin
    case (op)
      AND, TST: aluResult = rn & operand;
      EOR, TEQ: aluResult = rn ^ operand;
      ORR:      aluResult = rn | operand;
      MOV:      aluResult = operand;
      BIC:      aluResult = rn & ~operand;
      MVN:      aluResult = ~operand;
      default:  aluResult = sum[`EXEC_WORD_BITS-1:0];
    endcase
  end

  // Logical ops take C from the shifter and leave V alone
  assign nzcvNext = {aluResult[`EXEC_WORD_BITS-1],
                     aluResult == '0,
                     isArith ? sum[`EXEC_WORD_BITS] : shiftCarry,
                     isArith ? sumOverflow : overflowIn};

  assign writesReg = isMem | ~isCompare;  // Address always goes back

endmodule

// File: execCtrl.sv
`include "exec_settings.svh"

module execCtrl import execTypes_pkg::*; (
  input  logic                       clk,
  input  logic                       isLDRSTR_shift,
  input  logic                       opReq,
  input  logic [`EXEC_WORD_BITS-1:0] aluResult,
  input  logic [3:0]                 nzcvNext,
  input  logic                       writesReg,
  input  logic                       setFlags,
  input  logic                       isMem,
  input  aluOp                       op,
  output logic                       opAck,
  output logic [`EXEC_WORD_BITS-1:0] result,
  output logic                       resWrite,
  output logic [3:0]                 flags
);

  typedef enum logic {
    ctrlIdle,
    ctrlAck
  } ctrlState;

  ctrlState state;
  ctrlState stateNext;
  logic     accept;
  logic     isCompare;
  logic     loadFlags;

  assign accept    = (state == ctrlIdle) && opReq;
  assign isCompare = (op inside {TST, TEQ, CMP, CMN});
  // Memory ops never touch NZCV, compares always do
  assign loadFlags = accept && !isMem && (setFlags || isCompare);

  always_comb begin
    stateNext = state;
    case (state)
      ctrlIdle: begin
        if (opReq) begin
          stateNext = ctrlAck;
        end
      end
      default: begin
        if (!opReq) begin
          stateNext = ctrlIdle;  // Requester has seen the ack
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      state <= ctrlIdle;
    end else begin
      state <= stateNext;
    end
  end

  // Held through back-pressure until the next acceptance
  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      result   <= '0;
      resWrite <= 1'b0;
    end else if (accept) begin
      result   <= aluResult;
      resWrite <= writesReg;
    end
  end

  always_ff @(posedge clk) begin
    if (isLDRSTR_shift) begin
      flags <= 4'b0000;
    end else if (loadFlags) begin
      flags <= nzcvNext;
    end
  end

  assign opAck = (state == ctrlAck);

endmodule

// File: execUnit.sv
`include "exec_settings.svh"

module execUnit import execTypes_pkg::*; (
  input  logic                       clk,
  input  logic                       isLDRSTR_shift,
  input  logic                       opReq,
  output logic                       opAck,
  input  logic [`EXEC_WORD_BITS-1:0] instr,
  input  logic [`EXEC_WORD_BITS-1:0] rnVal,
  input  logic [`EXEC_WORD_BITS-1:0] rmVal,
  input  logic [`EXEC_WORD_BITS-1:0] rsVal,
  output logic [`EXEC_WORD_BITS-1:0] result,
  output logic                       resWrite,
  output logic [3:0]                 flags
);

  aluOp                       opSel;
  logic                       setFlags;
  logic                       isMem;
  logic [`EXEC_WORD_BITS-1:0] shA;
  logic [`EXEC_WORD_BITS-1:0] shB;
  logic                       isRtype;
  logic                       isRSRtype;
  logic                       isMemShift;
  logic                       ZeroRotate;
  logic [1:0]                 shiftOpCode_E;
  logic [`EXEC_WORD_BITS-1:0] shiftBE;
  logic                       shifterCarryOutE;
  logic [`EXEC_WORD_BITS-1:0] aluResult;
  logic [3:0]                 nzcvNext;
  logic                       writesReg;

  // Class and U are already folded into the other decode outputs
  instrDecode decode0 (
    .instr(instr), .rmVal(rmVal), .rsVal(rsVal),
    .opClass(), .op(opSel), .setFlags(setFlags), .isMem(isMem), .up(),
    .a(shA), .b(shB), .isRtype(isRtype), .isRSRtype(isRSRtype),
    .isMemShift(isMemShift), .ZeroRotate(ZeroRotate), .shiftOpCode_E(shiftOpCode_E)
  );

  shifter shifter0 (
    .a(shA), .b(shB), .isRtype(isRtype), .isRSRtype(isRSRtype),
    .isMemShift(isMemShift), .ZeroRotate(ZeroRotate),
    .prevCarry(flags[1]),  // Current C
    .shiftOpCode_E(shiftOpCode_E),
    .shiftBE(shiftBE), .shifterCarryOutE(shifterCarryOutE)
  );

  alu alu0 (
    .rn(rnVal), .operand(shiftBE), .shiftCarry(shifterCarryOutE),
    .carryIn(flags[1]), .overflowIn(flags[0]), .op(opSel), .isMem(isMem),
    .aluResult(aluResult), .nzcvNext(nzcvNext), .writesReg(writesReg)
  );

  execCtrl ctrl0 (
    .clk(clk), .isLDRSTR_shift(isLDRSTR_shift), .opReq(opReq),
    .aluResult(aluResult), .nzcvNext(nzcvNext), .writesReg(writesReg),
    .setFlags(setFlags), .isMem(isMem), .op(opSel),
    .opAck(opAck), .result(result), .resWrite(resWrite), .flags(flags)
  );

endmodule

// File: execChecker.sv
`include "exec_settings.svh"

module execChecker (
  input  logic                       clk,
  input  logic                       isLDRSTR_shift,
  input  logic                       opReq,
  input  logic                       opAck,
  input  logic [`EXEC_WORD_BITS-1:0] instr,
  input  logic [`EXEC_WORD_BITS-1:0] rnVal,
  input  logic [`EXEC_WORD_BITS-1:0] rmVal,
  input  logic [`EXEC_WORD_BITS-1:0] rsVal,
  input  logic [`EXEC_WORD_BITS-1:0] result,
  input  logic                       resWrite,
  input  logic [3:0]                 flags,
  output int                         passCount,
  output int                         failCount
);

  logic [31:0] expResult;
  logic        expWrite;
  logic [3:0]  modelFlags;  // Reference NZCV
  int          cyc;
  int          reqCycle;
  int          dropCycle;
  int          testNum;
  bit          reqSeen;
  bit          ackSeen;
  bit          dropSeen;
  bit          testBad;
  bit          resetChecked;

  // Register-style shift, amount already resolved
  task automatic shiftBy(input logic [1:0] typ, input int amt, input logic [31:0] v,
                         input logic cin, output logic [31:0] r, output logic cout);
    int rot;
    r    = v;
    cout = cin;
    rot  = amt % 32;
    if (amt == 0) return;
    case (typ)
      2'b00: begin
        r    = (amt < 32) ? v << amt : 32'h0;
        cout = (amt < 32) ? v[32-amt] : ((amt == 32) ? v[0] : 1'b0);
      end
      2'b01: begin
        r    = (amt < 32) ? v >> amt : 32'h0;
        cout = (amt < 32) ? v[amt-1] : ((amt == 32) ? v[31] : 1'b0);
      end
      2'b10: begin
        r    = (amt < 32) ? 32'($signed(v) >>> amt) : {32{v[31]}};
        cout = (amt < 32) ? v[amt-1] : v[31];
      end
      default: begin
        r    = (rot == 0) ? v : ((v >> rot) | (v << (32 - rot)));
        cout = (rot == 0) ? v[31] : v[rot-1];
      end
    endcase
  endtask

  // Second operand and shifter carry for one instruction
  task automatic operand2(input logic c, output logic [31:0] v, output logic cout);
    int amt;
    logic [1:0] typ;
    amt = int'(instr[11:7]);
    typ = instr[6:5];
    if (instr[27:26] != 2'b01 && instr[25]) begin
      amt  = 2 * int'(instr[11:8]);
      v    = (amt == 0) ? {24'h0, instr[7:0]} :
             (({24'h0, instr[7:0]} >> amt) | ({24'h0, instr[7:0]} << (32 - amt)));
      cout = (amt == 0) ? c : v[31];
    end else if (instr[27:26] != 2'b01 && instr[4]) begin
      shiftBy(typ, int'(rsVal[7:0]), rmVal, c, v, cout);
    end else begin
      if (amt == 0 && typ == 2'b11) begin  // RRX
        v    = {c, rmVal[31:1]};
        cout = rmVal[0];
      end else begin
        shiftBy(typ, (amt == 0 && typ != 2'b00) ? 32 : amt, rmVal, c, v, cout);
      end
      if (instr[27:26] == 2'b01) cout = 1'b0;
    end
  endtask

  // Predict result, write enable and next flags
  task automatic predict();
    logic [31:0] op2;
    logic        sc;
    logic [3:0]  opc;
    logic        isMem;
    longint      wide;
    longint      sw;
    logic [31:0] x;
    logic [31:0] y;
    logic        cin;
    logic        arith;
    logic        c;
    logic        v;
    operand2(modelFlags[1], op2, sc);
    isMem = (instr[27:26] == 2'b01);
    opc   = isMem ? (instr[23] ? 4'h4 : 4'h2) : instr[24:21];
    arith = (opc inside {[4'h2:4'h7], 4'hA, 4'hB});
    x     = rnVal;
    y     = op2;
    cin   = 1'b0;
    if (opc == 4'h3 || opc == 4'h7) begin
      x = op2;
      y = rnVal;
    end
    if (opc inside {4'h2, 4'h3, 4'hA}) cin = 1'b1;
    if (opc inside {4'h5, 4'h6, 4'h7}) cin = modelFlags[1];
    c = sc;
    v = modelFlags[0];
    case (opc)
      4'h0, 4'h8: expResult = rnVal & op2;
      4'h1, 4'h9: expResult = rnVal ^ op2;
      4'hC:       expResult = rnVal | op2;
      4'hD:       expResult = op2;
      4'hE:       expResult = rnVal & ~op2;
      4'hF:       expResult = ~op2;
      4'h4, 4'h5, 4'hB: begin
        wide      = longint'(x) + longint'(y) + longint'(cin);
        sw        = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
        expResult = wide[31:0];
        c         = wide > 64'hFFFFFFFF;
        v         = (sw > 64'sh7FFFFFFF) || (sw < -64'sh80000000);
      end
      default: begin  // Subtractions with borrow = !cin
        wide      = longint'(x) - longint'(y) - longint'(!cin);
        sw        = longint'($signed(x)) - longint'($signed(y)) - longint'(!cin);
        expResult = wide[31:0];
        c         = wide >= 0;
        v         = (sw > 64'sh7FFFFFFF) || (sw < -64'sh80000000);
      end
    endcase
    expWrite = isMem || !(opc inside {[4'h8:4'hB]});
    if (!isMem && (instr[20] || opc inside {[4'h8:4'hB]}))
      modelFlags = {expResult[31], expResult == 32'h0, arith ? c : sc, v};
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got) begin
      $display("ERR %0t %s expected %h got %h", $time, what, exp, got);
      testBad = 1'b1;
    end
  endtask

  always @(posedge clk) begin
    if (isLDRSTR_shift) begin
      modelFlags = 4'h0;
      cyc        = 0;
      passCount  = 0;
      failCount  = 0;
      testNum    = 0;
      reqSeen    = 0;
      ackSeen    = 0;
      dropSeen   = 0;
      testBad    = 0;
    end else begin
      cyc++;
      if (!resetChecked) begin  // Outputs straight out of reset
        resetChecked = 1;
        if (opAck || result != 0 || resWrite || flags != 0) begin
          $display("ERR %0t outputs not zero after reset", $time);
          failCount++;
        end
      end
      if (ackSeen && !opAck) begin
        if (!dropSeen) begin
          $display("ack dropped at %0t while request was still held", $time);
          testBad = 1'b1;
        end else if (cyc != dropCycle + 1) begin
          $display("ack fell late at %0t", $time);
          testBad = 1'b1;
        end
        $display("test %0d instr %h %s", testNum, instr, testBad ? "fail" : "ok");
        if (testBad) failCount++;
        else passCount++;
        testNum++;
        {reqSeen, ackSeen, dropSeen, testBad} = 4'b0000;
      end
      if (opReq && !reqSeen) begin
        reqSeen  = 1;
        reqCycle = cyc;
        if (opAck) begin
          $display("request raised at %0t while ack was still high", $time);
          testBad = 1'b1;
        end
        predict();
      end
      if (opAck && reqSeen && !ackSeen) begin
        ackSeen = 1;
        if (cyc != reqCycle + 1) begin
          $display("ack latency wrong at %0t", $time);
          testBad = 1'b1;
        end
        compare("result", expResult, result);
        compare("resWrite", {31'h0, expWrite}, {31'h0, resWrite});
        compare("flags", {28'h0, modelFlags}, {28'h0, flags});
      end
      if (!opReq && ackSeen && !dropSeen) begin
        dropSeen  = 1;
        dropCycle = cyc;
      end
    end
  end

endmodule

// File: tb_execUnit.sv
`include "exec_settings.svh"

module tb_execUnit;

  localparam int NUM_TESTS   = 400;
  localparam int SEED        = 67;
  localparam int CYCLE_LIMIT = NUM_TESTS * 8 + 50;

  logic                       clk;
  logic                       isLDRSTR_shift;
  logic                       opReq;
  logic                       opAck;
  logic [`EXEC_WORD_BITS-1:0] instr;
  logic [`EXEC_WORD_BITS-1:0] rnVal;
  logic [`EXEC_WORD_BITS-1:0] rmVal;
  logic [`EXEC_WORD_BITS-1:0] rsVal;
  logic [`EXEC_WORD_BITS-1:0] result;
  logic                       resWrite;
  logic [3:0]                 flags;
  logic [31:0]                lfsr;
  int                         passCount;
  int                         failCount;
  int                         cycles;

  execUnit dut0 (.*);

  execChecker check0 (.*);

  always #10 clk = ~clk;

  // Galois LFSR stepped once per bit with taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Edge amounts most of the time
  function automatic logic [7:0] pickAmount();
    logic [7:0] edges [8];
    logic [1:0] bias;
    logic [2:0] idx;
    edges = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd64, 8'd96, 8'd255};
    bias  = 2'(takeBits(2));
    if (bias != 2'd0) begin
      idx = 3'(takeBits(3));
      return edges[idx];
    end
    return 8'(takeBits(8));
  endfunction

  function automatic logic [31:0] buildInstr();
    logic [2:0]  cls;
    logic [31:0] w;
    cls = 3'(takeBits(3));
    w   = takeBits(32);
    w[27:26] = (cls == 3'd7) ? 2'b01 : 2'b00;
    if (cls <= 3'd1) begin  // Rotated immediate
      w[25]   = 1'b1;
      w[11:8] = takeBits(1) ? 4'h0 : 4'(takeBits(4));
    end else if (cls <= 3'd4) begin
      w[25]   = 1'b0;
      w[4]    = 1'b0;
      w[11:7] = 5'(pickAmount());
    end else if (cls <= 3'd6) begin
      w[25] = 1'b0;
      w[7]  = 1'b0;
      w[4]  = 1'b1;
    end else begin
      w[11:7] = 5'(pickAmount());
    end
    return w;
  endfunction

  task automatic runOne();
    int          hold;
    logic [23:0] rsHigh;
    @(posedge clk);
    instr  <= buildInstr();
    rnVal  <= takeBits(32);
    rmVal  <= takeBits(32);
    rsHigh = 24'(takeBits(24));
    rsVal  <= {rsHigh, pickAmount()};
    opReq  <= 1'b1;
    hold = int'(takeBits(2)) % 3;
    do @(negedge clk); while (!opAck);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    opReq <= 1'b0;
    do @(negedge clk); while (opAck);
  endtask

  always @(posedge clk) begin
    if (!isLDRSTR_shift) cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: handshake stalled");
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    clk            = 1'b0;
    isLDRSTR_shift = 1'b1;
    opReq          = 1'b0;
    instr          = '0;
    rnVal          = '0;
    rmVal          = '0;
    rsVal          = '0;
    cycles         = 0;
    lfsr           = 32'(SEED);
    repeat (4) @(posedge clk);
    isLDRSTR_shift <= 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      runOne();
    end
    @(posedge clk);
    @(negedge clk);
    $display("passed %0d failed %0d of %0d", passCount, failCount, NUM_TESTS);
    if (failCount == 0 && passCount == NUM_TESTS) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
execTypes_pkg.sv
instrDecode.sv
shifter.sv
alu.sv
execCtrl.sv
execUnit.sv
execChecker.sv
tb_execUnit.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_execUnit
RTL_TOP   ?= execUnit
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)
